// File: compile.f
+incdir+testbench
logic/rv64_exec_pkg.sv
logic/carry_adder.sv
logic/barrel_shifter.sv
logic/alu_control.sv
logic/alu_core.sv
logic/execute_stage.sv
testbench/execute_tb.sv

// File: logic/alu_control.sv
`timescale 1ns/1ns

module alu_control import rv64_exec_pkg::*; (
	input inst_word_u instr,
	output alu_op_t operation,
	output logic use_imm,
	output logic word_op,
	output logic illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic imm_form;
	logic word_form;
	logic dec_ok;
	alu_op_t dec_op;

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;

	assign imm_form = (opcode == opc_op_imm) || (opcode == opc_op_imm_32);
	assign word_form = (opcode == opc_op_32) || (opcode == opc_op_imm_32);

	always_comb begin
		dec_op = op_and;
		dec_ok = 1'b1;
		case (opcode)
			opc_op: begin // Has funct7 and funct3
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec_op = op_add;
					{7'b0100000, 3'b000}: dec_op = op_sub;
					{7'b0000000, 3'b001}: dec_op = op_sll;
					{7'b0000000, 3'b010}: dec_op = op_slt;
					{7'b0000000, 3'b011}: dec_op = op_sltu;
					{7'b0000000, 3'b100}: dec_op = op_xor;
					{7'b0000000, 3'b101}: dec_op = op_srl;
					{7'b0100000, 3'b101}: dec_op = op_sra;
					{7'b0000000, 3'b110}: dec_op = op_or;
					{7'b0000000, 3'b111}: dec_op = op_and;
					default: dec_ok = 1'b0;
				endcase
			end
			opc_op_imm: begin // Funct3 only
				case (funct3)
					3'b000: dec_op = op_add;
					3'b001: dec_op = op_sll;
					3'b010: dec_op = op_slt;
					3'b011: dec_op = op_sltu;
					3'b100: dec_op = op_xor;
					3'b101: dec_op = funct7[5] ? op_sra : op_srl; // Imm bit 10
					3'b110: dec_op = op_or;
					3'b111: dec_op = op_and;
				endcase
			end
			opc_op_32: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec_op = op_add;
					{7'b0100000, 3'b000}: dec_op = op_sub;
					{7'b0000000, 3'b001}: dec_op = op_sll;
					{7'b0000000, 3'b101}: dec_op = op_srl;
					{7'b0100000, 3'b101}: dec_op = op_sra;
					default: dec_ok = 1'b0;
				endcase
			end
			opc_op_imm_32: begin
				case (funct3)
					3'b000: dec_op = op_add;
					3'b001: dec_op = op_sll;
					3'b101: dec_op = funct7[5] ? op_sra : op_srl;
					default: dec_ok = 1'b0; // No ANDIW, ORIW and the like
				endcase
			end
			default: dec_ok = 1'b0;
		endcase
	end

	assign illegal = ~dec_ok;
	assign operation = dec_ok ? dec_op : op_and;
	assign use_imm = dec_ok & imm_form;
	assign word_op = dec_ok & word_form;

	// A rejected word must not steer operand B or word truncation downstream
	assert final (!illegal || (!use_imm && !word_op))
		else $error("alu_control: illegal decode with use_imm or word_op set");

endmodule

// File: logic/alu_core.sv
`timescale 1ns/1ns

module alu_core import rv64_exec_pkg::*; #(
	parameter int width = XLEN
) (
	input logic [width-1:0] operand_a,
	input logic [width-1:0] operand_b,
	input alu_op_t operation,
	input logic word_op,
	output logic [width-1:0] alu_result,
	output logic zero,
	output logic carry,
	output logic overflow
);

	logic [width-1:0] adder_sum;
	logic adder_carry;
	logic adder_overflow;
	logic [width-1:0] shift64_out;
	logic [31:0] shift32_out;
	logic [width-1:0] add_word;
	logic [width-1:0] shift_word;
	logic arith_op;

	carry_adder #(
		.width(width)
	) adder_inst (
		.in_a(operand_a),
		.in_b(operand_b),
		.subtract(operation[2]),
		.sum(adder_sum),
		.carry_out(adder_carry),
		.overflow(adder_overflow)
	);

	barrel_shifter #(
		.width(width)
	) shift64_inst (
		.din(operand_a),
		.shamt(operand_b[$clog2(width)-1:0]), // Low 6 bits at 64
		.shift_right(operation[0]),
		.arithmetic(operation[1]),
		.dout(shift64_out)
	);

	barrel_shifter #(
		.width(32)
	) shift32_inst (
		.din(operand_a[31:0]),
		.shamt(operand_b[4:0]),
		.shift_right(operation[0]),
		.arithmetic(operation[1]),
		.dout(shift32_out)
	);

	// W forms keep the low word and extend its bit 31
	assign add_word = {{(width-32){adder_sum[31]}}, adder_sum[31:0]};
	assign shift_word = {{(width-32){shift32_out[31]}}, shift32_out};

	always_comb begin
		case (operation)
			op_and: alu_result = operand_a & operand_b;
			op_or: alu_result = operand_a | operand_b;
			op_xor: alu_result = operand_a ^ operand_b;
			op_add, op_sub: alu_result = word_op ? add_word : adder_sum;
			op_slt: alu_result = {{(width-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
			op_sltu: alu_result = {{(width-1){1'b0}}, operand_a < operand_b};
			op_sll, op_srl, op_sra: alu_result = word_op ? shift_word : shift64_out;
			default: alu_result = '0;
		endcase
	end

	assign arith_op = (operation == op_add) || (operation == op_sub);

	assign zero = ~|alu_result;
	assign carry = arith_op & ~word_op & adder_carry; // Full-width add and sub only
	assign overflow = arith_op & ~word_op & adder_overflow;

	// The decoder only pairs word mode with add, sub and shifts
	assert final (!word_op || arith_op ||
		(operation inside {op_sll, op_srl, op_sra}))
		else $error("alu_core: word_op with logic or compare operation %h", operation);

endmodule

// File: logic/barrel_shifter.sv
`timescale 1ns/1ns

module barrel_shifter #(
	parameter int width = 64
) (
	input logic [width-1:0] din,
	input logic [$clog2(width)-1:0] shamt,
	input logic shift_right,
	input logic arithmetic,
	output logic [width-1:0] dout
);

	logic [2*width-1:0] window_r;
	logic [2*width-1:0] window_l;
	logic fill;

	assign fill = arithmetic & din[width-1]; // Sign fill for SRA only

	// Right shifts read upward from shamt, left shifts read downward
	assign window_r = {{width{fill}}, din};
	assign window_l = {din, {width{1'b0}}};

	always_comb begin
		if (shift_right) begin
			dout = window_r[shamt +: width];
		end else begin
			dout = window_l[(width - shamt) +: width]; // Zero shamt gives din
		end
	end

endmodule

// File: logic/carry_adder.sv
`timescale 1ns/1ns

module carry_adder #(
	parameter int width = 64
) (
	input logic [width-1:0] in_a,
	input logic [width-1:0] in_b,
	input logic subtract,
	output logic [width-1:0] sum,
	output logic carry_out,
	output logic overflow
);

	logic [width-1:0] b_eff;

	assign b_eff = in_b ^ {width{subtract}}; // Inverted B for subtract

	// Carry-in of one completes the two's complement
	assign {carry_out, sum} = {1'b0, in_a} + {1'b0, b_eff} + {{width{1'b0}}, subtract};

	// Same-sign inputs with a flipped result sign
	assign overflow = (in_a[width-1] == b_eff[width-1]) && (sum[width-1] != in_a[width-1]);

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import rv64_exec_pkg::*; #(
	parameter int width = XLEN
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input inst_word_u instr,
	input logic [width-1:0] rs1_data,
	input logic [width-1:0] rs2_data,
	output logic out_valid,
	output logic zero,
	output logic carry,
	output logic overflow,
	output logic illegal,
	output logic [width-1:0] result
);

	alu_op_t operation;
	logic use_imm;
	logic word_op;
	logic dec_illegal;
	logic [width-1:0] imm_ext;
	logic [width-1:0] operand_b;
	logic [width-1:0] alu_result;
	logic alu_zero;
	logic alu_carry;
	logic alu_overflow;

	alu_control control_inst (
		.instr(instr),
		.operation(operation),
		.use_imm(use_imm),
		.word_op(word_op),
		.illegal(dec_illegal)
	);

	assign imm_ext = {{(width-12){instr.i.imm12[11]}}, instr.i.imm12};
	assign operand_b = use_imm ? imm_ext : rs2_data;

	alu_core #(
		.width(width)
	) core_inst (
		.operand_a(rs1_data),
		.operand_b(operand_b),
		.operation(operation),
		.word_op(word_op),
		.alu_result(alu_result),
		.zero(alu_zero),
		.carry(alu_carry),
		.overflow(alu_overflow)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			result <= '0;
			zero <= 1'b0;
			carry <= 1'b0;
			overflow <= 1'b0;
			illegal <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin // Data holds between strobes
				result <= dec_illegal ? '0 : alu_result;
				zero <= dec_illegal | alu_zero; // Illegal result is zero
				carry <= alu_carry;
				overflow <= alu_overflow;
				illegal <= dec_illegal;
			end
		end
	end

	// One cycle of latency, no stalls
	assert property (@(posedge clk) disable iff (rst) in_valid |=> out_valid);
	assert property (@(posedge clk) disable iff (rst) !in_valid |=> !out_valid);

endmodule

// File: logic/rv64_exec_pkg.sv
package rv64_exec_pkg;

	localparam int XLEN = 64;

	typedef logic [3:0] alu_op_t;

	// Bit 2 means subtract, bit 3 the unsigned or shift group
	localparam alu_op_t op_and  = 4'b0000;
	localparam alu_op_t op_or   = 4'b0001;
	localparam alu_op_t op_add  = 4'b0010;
	localparam alu_op_t op_sub  = 4'b0110;
	localparam alu_op_t op_slt  = 4'b0111;
	localparam alu_op_t op_sltu = 4'b1111;
	localparam alu_op_t op_sll  = 4'b1000; // Bit 0 picks right, bit 1 arithmetic
	localparam alu_op_t op_srl  = 4'b1001;
	localparam alu_op_t op_sra  = 4'b1011;
	localparam alu_op_t op_xor  = 4'b1100;

	// Major opcodes handled by the stage
	localparam logic [6:0] opc_op        = 7'b0110011;
	localparam logic [6:0] opc_op_imm    = 7'b0010011;
	localparam logic [6:0] opc_op_32     = 7'b0111011;
	localparam logic [6:0] opc_op_imm_32 = 7'b0011011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fields_t;

	typedef struct packed {
		logic [11:0] imm12; // Shift forms keep funct7 in the top bits
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} inst_word_u;

endpackage

// File: testbench/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic [63:0] sext_word(input logic [31:0] w);
	return {{32{w[31]}}, w};
endfunction

// Encodings the stage accepts among the four major opcodes
function automatic logic legal_instr(input inst_word_u ins);
	logic [2:0] f3;
	logic [6:0] f7;
	f3 = ins.r.funct3;
	f7 = ins.r.funct7;
	case (ins.r.opcode)
		opc_op: return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 inside {3'd0, 3'd5}));
		opc_op_imm: return 1'b1;
		opc_op_32: return ((f3 inside {3'd0, 3'd5}) && (f7 inside {7'h00, 7'h20})) ||
			((f3 == 3'd1) && (f7 == 7'h00));
		opc_op_imm_32: return f3 inside {3'd0, 3'd1, 3'd5};
		default: return 1'b0;
	endcase
endfunction

// RV64I result, {zero, carry, overflow} and illegal bit for one item
function automatic void model_exec(input inst_word_u ins, input logic [63:0] a,
	input logic [63:0] rs2, output logic [63:0] res, output logic [2:0] flags,
	output logic ill);
	logic [64:0] sum;
	logic [63:0] b;
	logic [5:0] sh;
	logic is_imm;
	logic is_word;
	logic alt;
	logic c;
	logic v;
	is_imm = ins.r.opcode inside {opc_op_imm, opc_op_imm_32};
	is_word = ins.r.opcode inside {opc_op_32, opc_op_imm_32};
	alt = ins.r.funct7[5]; // SUB and SRA, imm bit 10 for I-type
	b = is_imm ? {{52{ins.i.imm12[11]}}, ins.i.imm12} : rs2;
	sh = is_word ? {1'b0, b[4:0]} : b[5:0];
	ill = !legal_instr(ins);
	res = '0;
	c = 1'b0;
	v = 1'b0;
	if (!ill) begin
		case (ins.r.funct3)
			3'd0: begin
				if (alt && !is_imm) begin
					res = a - b;
					c = a >= b; // Carry set means no borrow
					v = (a[63] != b[63]) && (res[63] != a[63]);
				end else begin
					sum = {1'b0, a} + {1'b0, b};
					res = sum[63:0];
					c = sum[64];
					v = (a[63] == b[63]) && (res[63] != a[63]);
				end
				if (is_word) begin
					res = sext_word(res[31:0]);
					c = 1'b0;
					v = 1'b0;
				end
			end
			3'd1: res = is_word ? sext_word(a[31:0] << sh) : a << sh;
			3'd2: res = {63'd0, $signed(a) < $signed(b)};
			3'd3: res = {63'd0, a < b};
			3'd4: res = a ^ b;
			3'd5: begin
				if (is_word && alt) res = sext_word($signed(a[31:0]) >>> sh);
				else if (is_word) res = sext_word(a[31:0] >> sh);
				else if (alt) res = $signed(a) >>> sh;
				else res = a >> sh;
			end
			3'd6: res = a | b;
			default: res = a & b;
		endcase
	end
	flags = {res == 64'd0, c, v};
endfunction

`endif

// File: testbench/execute_tb.sv
`timescale 1ns/1ns

module execute_tb import rv64_exec_pkg::*; ();

	localparam int total_items = 908;
	localparam int watchdog_ns = (total_items + 64) * 8 * 2;

	logic clk;
	logic rst;
	logic in_valid;
	inst_word_u instr;
	logic [63:0] rs1_data;
	logic [63:0] rs2_data;
	logic out_valid;
	logic zero;
	logic carry;
	logic overflow;
	logic illegal;
	logic [63:0] result;
	logic valid_d = 1'b0; // Strobe the DUT took at the last edge
	logic [63:0] exp_result[$];
	logic [2:0] exp_flags[$];
	logic exp_ill[$];
	string exp_name[$];
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	`include "exec_model.svh"

	execute_stage #(.width(XLEN)) execute_stage_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the run stopped making progress", watchdog_ns);
		$display("Simulation failed");
		$finish;
	end

	task automatic check_result(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		if (act !== exp) begin
			$display("ERROR %s: result expected %h actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp) begin
			$display("ERROR %s: zero/carry/overflow expected %b actual %b", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b actual %b", name, exp, act);
			test_errors++;
		end
	endtask

	function automatic logic [63:0] rand_operand();
		case ($urandom_range(3))
			0: return {$urandom, $urandom};
			1: return 64'($urandom_range(255));
			2: return -64'($urandom_range(255));
			default: return {$urandom, 32'h7fff_ffff + 32'($urandom_range(2))}; // Word edge
		endcase
	endfunction

	// Random instruction word of one class, register fields random
	function automatic inst_word_u rand_instr(input int kind);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [6:0] opc;
		logic alt;
		f3 = 3'($urandom);
		f7 = 7'($urandom);
		opc = 7'($urandom);
		alt = 1'($urandom);
		case (kind)
			0: begin
				opc = opc_op;
				f7 = (alt && (f3 inside {3'd0, 3'd5})) ? 7'h20 : 7'h00;
			end
			1: begin
				opc = opc_op_imm;
				if (f3 == 3'd1) f7 = {6'd0, f7[0]}; // Shamt bit 5 only
				if (f3 == 3'd5) f7 = {1'b0, alt, 4'd0, f7[0]};
			end
			2: begin
				opc = $urandom_range(1) ? opc_op_32 : opc_op_imm_32;
				f3 = f3[1] ? 3'd5 : {2'd0, f3[0]};
				if (opc == opc_op_32 || f3 != 3'd0) f7 = (alt && f3 != 3'd1) ? 7'h20 : 7'h00;
			end
			3: begin
				opc = opc_op;
				f3 = 3'd0;
				f7 = alt ? 7'h20 : 7'h00;
			end
			default: begin
				while (f3 inside {3'd0, 3'd1, 3'd5})
					f3 = 3'($urandom);
				case ($urandom_range(3))
					0: begin
						while (opc inside {opc_op, opc_op_imm, opc_op_32, opc_op_imm_32})
							opc = 7'($urandom);
					end
					1: opc = opc_op_imm_32; // ANDIW and friends
					2: opc = opc_op_32;
					default: begin
						opc = opc_op;
						f7 = f7 | 7'h01; // No valid funct7 has bit 0
					end
				endcase
			end
		endcase
		return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), opc};
	endfunction

	task automatic send(input string name, input inst_word_u ins, input logic [63:0] a,
		input logic [63:0] b);
		logic [63:0] res;
		logic [2:0] flags;
		logic ill;
		model_exec(ins, a, b, res, flags, ill);
		@(posedge clk);
		in_valid <= 1'b1;
		instr <= ins;
		rs1_data <= a;
		rs2_data <= b;
		exp_result.push_back(res);
		exp_flags.push_back(flags);
		exp_ill.push_back(ill);
		exp_name.push_back(name);
	endtask

	task automatic finish_test(input string name, input int n);
		int waited;
		@(posedge clk);
		in_valid <= 1'b0;
		waited = 0;
		while (exp_result.size() != 0 && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (exp_result.size() != 0) begin
			$display("%s: out_valid never came for %0d items", name, exp_result.size());
			test_errors += exp_result.size();
			exp_result.delete();
			exp_flags.delete();
			exp_ill.delete();
			exp_name.delete();
		end
		@(negedge clk);
		$display("%s: %0d items, %0d errors", name, n, test_errors);
		if (test_errors == 0) tests_passed++;
		else tests_failed++;
		test_errors = 0;
	endtask

	task automatic run_test(input string name, input int kind, input int n, input int max_gap);
		repeat (n) begin
			send(name, rand_instr(kind), rand_operand(), rand_operand());
			repeat ($urandom_range(max_gap)) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		finish_test(name, n);
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (out_valid !== valid_d) begin
				if (valid_d)
					$display("out_valid came late or not at all after a strobe, at %0t", $time);
				else
					$display("out_valid came early, with no strobe one cycle before, at %0t", $time);
				test_errors++;
			end
			if (out_valid === 1'b1 && exp_result.size() != 0) begin
				check_result(exp_name[0], exp_result.pop_front(), result);
				check_flags(exp_name[0], exp_flags.pop_front(), {zero, carry, overflow});
				check_bit(exp_name.pop_front(), exp_ill.pop_front(), illegal);
			end
		end
		valid_d = in_valid && !rst;
	end

	initial begin
		inst_word_u add_op;
		inst_word_u sub_op;
		void'($urandom(32'hb0e7523d));
		rst = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		rs1_data = '0;
		rs2_data = '0;
		add_op = {7'h00, 5'd2, 5'd1, 3'd0, 5'd3, opc_op};
		sub_op = {7'h20, 5'd2, 5'd1, 3'd0, 5'd3, opc_op};
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("reset_valid", 1'b0, out_valid);
		check_bit("reset_illegal", 1'b0, illegal);
		check_result("reset_result", 64'd0, result);
		finish_test("reset", 0);
		run_test("r_type", 0, 200, 0);
		run_test("i_type", 1, 200, 0);
		run_test("word", 2, 150, 0);
		send("flag_edges", add_op, 64'h7fff_ffff_ffff_ffff, 64'd1); // Signed overflow
		send("flag_edges", sub_op, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0);
		send("flag_edges", add_op, '1, 64'd1); // Wraps to zero with carry
		send("flag_edges", sub_op, 64'd0, 64'd1);
		send("flag_edges", add_op, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
		send("flag_edges", sub_op, 64'h8000_0000_0000_0000, 64'd1);
		send("flag_edges", {7'h00, 5'd2, 5'd1, 3'd4, 5'd3, opc_op}, '1, '1);
		send("flag_edges", {7'h00, 5'd2, 5'd1, 3'd1, 5'd3, opc_op}, 64'h8000_0000_0000_0000, 1);
		finish_test("flag_edges", 8);
		run_test("flags", 3, 100, 0);
		run_test("illegal", 4, 100, 0);
		run_test("timing", 0, 150, 2); // Gaps of zero give back-to-back items
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
